// ==== verilog/pet_pkg.sv ====
// Bus widths, data types, device timing constants, PET address map and phase-schedule function
package pet_pkg;

    // Bus widths
    localparam int unsigned WB_ADDR_WIDTH  = 20;    // Host address, 1 MiB window
    localparam int unsigned RAM_ADDR_WIDTH = 17;    // 128 KiB SRAM
    localparam int unsigned CPU_ADDR_WIDTH = 16;
    localparam int unsigned DATA_WIDTH     = 8;

    typedef logic [WB_ADDR_WIDTH-1:0]  wb_addr_t;
    typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;
    typedef logic [CPU_ADDR_WIDTH-1:0] cpu_addr_t;
    typedef logic [DATA_WIDTH-1:0]     data_t;

    localparam int unsigned PHASE_BITS    = 6;     // 64 host clocks per CPU cycle
    localparam int unsigned MAX_WB_CYCLES = 3;     // Acceptance to ack of one host transfer

    typedef logic [PHASE_BITS-1:0] phase_t;

    // Phase values at which the sequencer outputs change, in schedule order
    typedef struct packed {
        phase_t wb_ready_end;       // Host stops being admitted
        phase_t cpu_be_start;       // Host transfers drained, CPU leaves high-Z
        phase_t bus_valid_start;    // CPU address, RWB and data out settled
        phase_t io_valid_start;     // SRAM access or transceiver delay met
        phase_t cpu_phi_start;      // Data setup met, Phi2 rises
        phase_t cpu_phi_end;        // Minimum Phi2 high width met
        phase_t cpu_be_end;         // Hold times met, CPU back to high-Z
        phase_t wb_ready_start;     // CPU off the bus, host admitted again
    } phase_sched_t;

    // W65C02S / W65C21 / SRAM times in ns
    localparam int unsigned CPU_T_BVD = 30;    // BE to valid data
    localparam int unsigned CPU_T_PWH = 62;    // Phi2 high pulse width
    localparam int unsigned CPU_T_DSR = 15;    // Read data setup
    localparam int unsigned CPU_T_DH  = 10;    // Read/write data hold
    localparam int unsigned RAM_T_AA  = 10;    // SRAM address access
    localparam int unsigned IOTX_T    = 11;    // I/O transceiver worst-case enable

    // PET memory map, match when (addr & mask) == base
    localparam cpu_addr_t RAM_LO_BASE = 16'h0000;  // 0000-7FFF main RAM
    localparam cpu_addr_t RAM_LO_MASK = 16'h8000;
    localparam cpu_addr_t VRAM_BASE   = 16'h8000;  // 8000-8FFF video RAM, treated as RAM
    localparam cpu_addr_t VRAM_MASK   = 16'hF000;
    localparam cpu_addr_t IO_BASE     = 16'hE800;  // E800-E8FF I/O page
    localparam cpu_addr_t IO_MASK     = 16'hFF00;
    localparam cpu_addr_t PIA1_BASE   = 16'hE810;
    localparam cpu_addr_t PIA2_BASE   = 16'hE820;
    localparam cpu_addr_t VIA_BASE    = 16'hE840;
    localparam cpu_addr_t CHIP_MASK   = 16'hFFF0;  // 16 registers per I/O chip

    // ns to clocks, rounded up, one extra clock for propagation delay
    function automatic phase_t ns_to_cycles(input int unsigned time_ns,
                                            input int unsigned clock_mhz);
        return phase_t'((time_ns * clock_mhz + 999) / 1000 + 1);
    endfunction

    function automatic phase_sched_t phase_schedule(input int unsigned clock_mhz);
        phase_sched_t s;
        int unsigned  io_t;
        io_t              = (IOTX_T > RAM_T_AA) ? IOTX_T : RAM_T_AA;
        s.wb_ready_end    = '0;
        s.cpu_be_start    = phase_t'(MAX_WB_CYCLES);  // Last host ack lands before this
        s.bus_valid_start = s.cpu_be_start    + ns_to_cycles(CPU_T_BVD, clock_mhz);
        s.io_valid_start  = s.bus_valid_start + ns_to_cycles(io_t, clock_mhz);
        s.cpu_phi_start   = s.io_valid_start  + ns_to_cycles(CPU_T_DSR, clock_mhz);
        s.cpu_phi_end     = s.cpu_phi_start   + ns_to_cycles(CPU_T_PWH, clock_mhz);
        s.cpu_be_end      = s.cpu_phi_end     + ns_to_cycles(CPU_T_DH, clock_mhz);
        s.wb_ready_start  = s.cpu_be_end      + ns_to_cycles(CPU_T_BVD, clock_mhz);
        return s;
    endfunction

endpackage

// ==== verilog/wb_bus_if.sv ====
// Wishbone B4 pipelined bus interface with host and device modports
`timescale 1ns/1ps

interface wb_bus_if;

    pet_pkg::wb_addr_t adr;      // Host byte address
    pet_pkg::data_t    dat_w;    // Write data, host to device
    pet_pkg::data_t    dat_r;    // Read data, valid with ack
    logic              we;       // 1 = write
    logic              cyc;      // Bus cycle in progress
    logic              stb;      // Request strobe
    logic              stall;    // Device cannot take a request this clock
    logic              ack;      // Transfer done, one clock wide

    // Request side, used by the bus sequencer
    modport host (
        output adr,
        output dat_w,
        output we,
        output cyc,
        output stb,
        input  dat_r,
        input  stall,
        input  ack
    );

    // Response side, used by the RAM controller
    modport device (
        input  adr,
        input  dat_w,
        input  we,
        input  cyc,
        input  stb,
        output dat_r,
        output stall,
        output ack
    );

endinterface

// ==== verilog/bus_sequencer.sv ====
// Bus sequencer: phase counter, Phi2 and BE generation, host request gating
`timescale 1ns/1ps

module bus_sequencer #(
    parameter int unsigned WB_CLOCK_MHZ = 64
) (
    input  logic              wb_clock_i,
    input  logic              rst_n_i,

    // External host request, gated into the device bus
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    output logic              wb_stall_o,
    wb_bus_if.host            wb,
    input  pet_pkg::wb_addr_t wb_adr_i,
    input  pet_pkg::data_t    wb_dat_i,
    input  logic              wb_we_i,

    // CPU timing
    output logic              cpu_be_o,
    output logic              cpu_clock_o,
    output logic              bus_valid_o,
    output logic              io_valid_o
);

    // Schedule fixed at elaboration from the host clock
    localparam pet_pkg::phase_sched_t SCHED = pet_pkg::phase_schedule(WB_CLOCK_MHZ);

    pet_pkg::phase_t phase_q;   // Position within the CPU cycle
    logic            wb_ready;  // Host window open

    // Free-running, wraps every 64 clocks
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // Each output changes at the edge where the counter holds its phase value
    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ready    <= 1'b0;    // Stall host until first host window
            cpu_be_o    <= 1'b0;    // CPU stays off the bus
            bus_valid_o <= 1'b0;
            io_valid_o  <= 1'b0;
            cpu_clock_o <= 1'b0;
        end else begin
            case (phase_q)
                SCHED.wb_ready_end: begin
                    wb_ready <= 1'b0;       // Close host window
                end
                SCHED.cpu_be_start: begin
                    cpu_be_o <= 1'b1;       // Any accepted transfer has acked by now
                end
                SCHED.bus_valid_start: begin
                    bus_valid_o <= 1'b1;    // CPU address and RWB usable for decode
                end
                SCHED.io_valid_start: begin
                    io_valid_o <= 1'b1;     // Chip selects and SRAM read enable allowed
                end
                SCHED.cpu_phi_start: begin
                    cpu_clock_o <= 1'b1;    // Setup met, CPU transfer starts
                end
                SCHED.cpu_phi_end: begin
                    cpu_clock_o <= 1'b0;    // CPU advances to next state
                end
                SCHED.cpu_be_end: begin
                    // Hold times met, release the bus
                    cpu_be_o    <= 1'b0;
                    bus_valid_o <= 1'b0;
                    io_valid_o  <= 1'b0;
                end
                SCHED.wb_ready_start: begin
                    wb_ready <= 1'b1;       // CPU in high-Z, host may go
                end
                default: begin
                end
            endcase
        end
    end

    // Requests reach the RAM controller only inside the host window
    assign wb.cyc   = wb_ready & wb_cyc_i;
    assign wb.stb   = wb_ready & wb_stb_i;
    assign wb.adr   = wb_adr_i;
    assign wb.dat_w = wb_dat_i;
    assign wb.we    = wb_we_i;

    // Host holds its request while the window is shut or the controller is busy
    assign wb_stall_o = ~wb_ready | wb.stall;

endmodule

// ==== verilog/ram_controller.sv ====
// RAM controller: Wishbone device that sequences SRAM strobes for host reads and writes
`timescale 1ns/1ps

module ram_controller (
    input  logic               wb_clock_i,
    input  logic               rst_n_i,
    wb_bus_if.device           wb,

    // Shared SRAM bus
    output logic               ram_oe_o,
    output logic               ram_we_o,
    output pet_pkg::ram_addr_t ram_addr_o,
    input  pet_pkg::data_t     ram_data_i,
    output pet_pkg::data_t     ram_data_o,
    output logic               ram_data_oe_o
);

    // Clock count after acceptance; ACK is clock MAX_WB_CYCLES
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        STROBE = 2'd1,  // SRAM strobe, write pulse here
        SAMPLE = 2'd2,  // Read data settled, captured at end of clock
        ACK    = 2'd3   // Ack with captured data
    } state_t;

    state_t             state_q;
    logic               accept;
    logic               we_q;       // Direction of transfer in flight
    pet_pkg::ram_addr_t addr_q;
    pet_pkg::data_t     wdata_q;
    pet_pkg::data_t     rdata_q;

    // Accepted on an edge with a request and no stall
    assign accept = wb.cyc & wb.stb & ~wb.stall;

    always_ff @(posedge wb_clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q <= STROBE;
                    end
                end
                STROBE:  state_q <= SAMPLE;
                SAMPLE:  state_q <= ACK;
                ACK:     state_q <= IDLE;   // Single transfer done
                default: state_q <= IDLE;
            endcase
        end
    end

    // Request payload, latched once per transfer
    always_ff @(posedge wb_clock_i) begin
        if (accept) begin
            we_q    <= wb.we;
            addr_q  <= pet_pkg::ram_addr_t'(wb.adr[pet_pkg::RAM_ADDR_WIDTH-1:0]);
            wdata_q <= wb.dat_w;
        end
    end

    // Read data captured at end of clock 2
    always_ff @(posedge wb_clock_i) begin
        if (state_q == SAMPLE) begin
            rdata_q <= ram_data_i;
        end
    end

    // Busy until the ack clock has passed
    assign wb.stall = (state_q != IDLE);
    assign wb.ack   = (state_q == ACK);
    assign wb.dat_r = rdata_q;

    // SRAM side
    assign ram_addr_o    = addr_q;
    assign ram_data_o    = wdata_q;
    assign ram_data_oe_o = we_q & (state_q != IDLE);                         // Acceptance to ack
    assign ram_oe_o      = ~we_q & ((state_q == STROBE) | (state_q == SAMPLE)); // Clocks 1 and 2
    assign ram_we_o      = we_q & (state_q == STROBE);                        // Clock 1 only

endmodule

// ==== verilog/address_decoder.sv ====
// Address decoder: PET memory map to RAM, I/O page and PIA1/PIA2/VIA enables
`timescale 1ns/1ps

module address_decoder (
    input  pet_pkg::cpu_addr_t addr_i,
    output logic               ram_en_o,
    output logic               io_en_o,
    output logic               pia1_en_o,
    output logic               pia2_en_o,
    output logic               via_en_o
);

    // True when the masked address bits equal the region base
    function automatic logic in_region(input pet_pkg::cpu_addr_t addr,
                                       input pet_pkg::cpu_addr_t base,
                                       input pet_pkg::cpu_addr_t mask);
        return (addr & mask) == base;
    endfunction

    logic ram_lo_hit;   // 0000-7FFF
    logic vram_hit;     // 8000-8FFF
    logic io_hit;       // E800-E8FF

    assign ram_lo_hit = in_region(addr_i, pet_pkg::RAM_LO_BASE, pet_pkg::RAM_LO_MASK);
    assign vram_hit   = in_region(addr_i, pet_pkg::VRAM_BASE, pet_pkg::VRAM_MASK);
    assign io_hit     = in_region(addr_i, pet_pkg::IO_BASE, pet_pkg::IO_MASK);

    // Video RAM lives in the same SRAM
    assign ram_en_o = ram_lo_hit | vram_hit;
    assign io_en_o  = io_hit;

    // Chip enables only inside the I/O page
    assign pia1_en_o = io_hit & in_region(addr_i, pet_pkg::PIA1_BASE, pet_pkg::CHIP_MASK);
    assign pia2_en_o = io_hit & in_region(addr_i, pet_pkg::PIA2_BASE, pet_pkg::CHIP_MASK);
    assign via_en_o  = io_hit & in_region(addr_i, pet_pkg::VIA_BASE, pet_pkg::CHIP_MASK);

    // ROM and unmapped space fall through with every enable low

endmodule

// ==== verilog/pet_system.sv ====
// PET bus core top level: sequencer, RAM controller, decoder, select qualification, address muxes
`timescale 1ns/1ps

module pet_system #(
    parameter int unsigned WB_CLOCK_MHZ = 64
) (
    // Wishbone B4 pipelined host port
    input  logic                wb_clock_i,
    input  logic                rst_n_i,
    input  pet_pkg::wb_addr_t   wb_addr_i,
    input  pet_pkg::data_t      wb_data_i,
    output pet_pkg::data_t      wb_data_o,
    input  logic                wb_we_i,
    input  logic                wb_cycle_i,
    input  logic                wb_strobe_i,
    output logic                wb_stall_o,
    output logic                wb_ack_o,

    // CPU
    output logic                cpu_be_o,
    output logic                cpu_ready_o,
    output logic                cpu_clock_o,
    input  pet_pkg::cpu_addr_t  cpu_addr_i,
    output pet_pkg::cpu_addr_t  cpu_addr_o,
    output logic                cpu_addr_oe_o,
    input  pet_pkg::data_t      cpu_data_i,
    output pet_pkg::data_t      cpu_data_o,
    output logic                cpu_data_oe_o,
    input  logic                cpu_we_i,
    output logic                cpu_we_o,
    output logic                cpu_we_oe_o,

    // SRAM upper address lines and strobes
    output logic                ram_addr_a10_o,
    output logic                ram_addr_a11_o,
    output logic                ram_addr_a15_o,
    output logic                ram_addr_a16_o,
    output logic                ram_oe_o,
    output logic                ram_we_o,

    // I/O
    output logic                io_oe_o,
    output logic                pia1_cs_o,
    output logic                pia2_cs_o,
    output logic                via_cs_o
);

    wb_bus_if wb ();    // Sequencer to RAM controller

    logic               bus_valid;
    logic               io_valid;
    logic               host_ram_oe;    // Strobes from host transfers
    logic               host_ram_we;
    pet_pkg::ram_addr_t host_ram_addr;
    logic               ram_en;
    logic               io_en;
    logic               pia1_en;
    logic               pia2_en;
    logic               via_en;

    bus_sequencer #(
        .WB_CLOCK_MHZ(WB_CLOCK_MHZ)
    ) bus_sequencer_inst (
        .wb_clock_i (wb_clock_i),
        .rst_n_i    (rst_n_i),
        .wb_cyc_i   (wb_cycle_i),
        .wb_stb_i   (wb_strobe_i),
        .wb_stall_o (wb_stall_o),
        .wb         (wb),
        .wb_adr_i   (wb_addr_i),
        .wb_dat_i   (wb_data_i),
        .wb_we_i    (wb_we_i),
        .cpu_be_o   (cpu_be_o),
        .cpu_clock_o(cpu_clock_o),
        .bus_valid_o(bus_valid),
        .io_valid_o (io_valid)
    );

    ram_controller ram_controller_inst (
        .wb_clock_i   (wb_clock_i),
        .rst_n_i      (rst_n_i),
        .wb           (wb),
        .ram_oe_o     (host_ram_oe),
        .ram_we_o     (host_ram_we),
        .ram_addr_o   (host_ram_addr),
        .ram_data_i   (cpu_data_i),     // Shared data bus
        .ram_data_o   (cpu_data_o),
        .ram_data_oe_o(cpu_data_oe_o)
    );

    address_decoder address_decoder_inst (
        .addr_i   (cpu_addr_i),
        .ram_en_o (ram_en),
        .io_en_o  (io_en),
        .pia1_en_o(pia1_en),
        .pia2_en_o(pia2_en),
        .via_en_o (via_en)
    );

    assign wb_data_o = wb.dat_r;
    assign wb_ack_o  = wb.ack;

    // No wait states yet; CPU never drives RWB from this side
    assign cpu_ready_o = 1'b1;
    assign cpu_we_o    = 1'b0;
    assign cpu_we_oe_o = 1'b0;

    // Decode qualified by the bus phase
    assign io_oe_o   = io_en & bus_valid;
    assign pia1_cs_o = pia1_en & io_valid;
    assign pia2_cs_o = pia2_en & io_valid;
    assign via_cs_o  = via_en & io_valid;

    // CPU read enables SRAM in the io_valid window, CPU write strobes on Phi2
    assign ram_oe_o = (ram_en & io_valid & ~cpu_we_i) | host_ram_oe;
    assign ram_we_o = (ram_en & cpu_clock_o & cpu_we_i) | host_ram_we;

    // Host drives the address bus whenever the CPU is off it
    assign cpu_addr_oe_o = ~cpu_be_o;
    assign cpu_addr_o    = host_ram_addr[pet_pkg::CPU_ADDR_WIDTH-1:0];

    assign ram_addr_a10_o = cpu_be_o ? cpu_addr_i[10] : host_ram_addr[10];
    assign ram_addr_a11_o = cpu_be_o ? cpu_addr_i[11] : host_ram_addr[11];
    assign ram_addr_a15_o = cpu_be_o ? cpu_addr_i[15] : host_ram_addr[15];
    assign ram_addr_a16_o = cpu_be_o ? 1'b0 : host_ram_addr[16];   // CPU sees lower 64 KiB

endmodule

// ==== tests/tb_pet_checks.svh ====
// Concurrent bus properties, check counters and per-test result reporting
`ifndef TB_PET_CHECKS_SVH
`define TB_PET_CHECKS_SVH

int pass_count   = 0;
int fail_count   = 0;
int tests_run    = 0;
int tests_failed = 0;
int test_base    = 0;   // fail_count when the current test started

task automatic report_mismatch(input string sig, input logic [31:0] exp,
                               input logic [31:0] got);
    fail_count++;
    $display("Fail %s: expected 0x%h, got 0x%h at %0t ns", sig, exp, got, $time);
endtask

task automatic report_problem(input string what);
    fail_count++;
    $display("Error: %s at %0t ns", what, $time);
endtask

// Immediate compare, counted either way
task automatic expect_eq(input string sig, input logic [31:0] exp, input logic [31:0] got);
    assert (got === exp) pass_count++;
    else report_mismatch(sig, exp, got);
endtask

task automatic finish_test(input string name);
    int errs;
    errs = fail_count - test_base;
    tests_run++;
    if (errs != 0) begin
        tests_failed++;
        $display("Test %0d %s: failed with %0d errors", tests_run, name, errs);
    end else begin
        $display("Test %0d %s: passed", tests_run, name);
    end
    test_base = fail_count;
endtask

// Host acks must land before the CPU owns the bus
a_ack_host_window: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
    wb_ack_o |-> !cpu_be_o)
    else report_mismatch("cpu_be_o during wb_ack_o", 0, 1);

// Address output enable is the inverse of BE
a_addr_oe: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
    cpu_addr_oe_o == !cpu_be_o)
    else report_mismatch("cpu_addr_oe_o", !$sampled(cpu_be_o), $sampled(cpu_addr_oe_o));

// No wait states and no RWB drive, also while in reset
a_cpu_ties: assert property (@(posedge wb_clock_i)
    cpu_ready_o && !cpu_we_o && !cpu_we_oe_o)
    else report_problem("cpu_ready_o, cpu_we_o or cpu_we_oe_o left its fixed level");

// Upper SRAM lines from the CPU inside its window
a_cpu_mux: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
    cpu_be_o |-> ({ram_addr_a16_o, ram_addr_a15_o, ram_addr_a11_o, ram_addr_a10_o}
                  == {1'b0, cpu_addr_i[15], cpu_addr_i[11], cpu_addr_i[10]}))
    else report_mismatch("ram_addr a16/a15/a11/a10",
        {1'b0, $sampled(cpu_addr_i[15]), $sampled(cpu_addr_i[11]), $sampled(cpu_addr_i[10])},
        {$sampled(ram_addr_a16_o), $sampled(ram_addr_a15_o),
         $sampled(ram_addr_a11_o), $sampled(ram_addr_a10_o)});

// ROM space selects nothing
a_rom_quiet: assert property (@(posedge wb_clock_i) disable iff (!rst_n_i)
    (cpu_be_o && is_rom(cpu_addr_i)) |->
        !(pia1_cs_o | pia2_cs_o | via_cs_o | io_oe_o | ram_oe_o | ram_we_o))
    else report_problem("an enable was raised for a ROM address");

`endif

// ==== tests/tb_pet_system.sv ====
// Testbench top: clock, reset, SRAM model, stimulus, watchdog and reporting for pet_system
`timescale 1ns/1ps

module tb_pet_system;

    localparam int CLK_NS      = 100;
    localparam int WATCHDOG_NS = 6 * 40 * 64 * CLK_NS;     // Tests x periods x clocks

    logic        wb_clock_i;
    logic        rst_n_i;
    logic [19:0] wb_addr_i;
    logic [7:0]  wb_data_i;
    logic [7:0]  wb_data_o;
    logic        wb_we_i, wb_cycle_i, wb_strobe_i, wb_stall_o, wb_ack_o;
    logic        cpu_be_o, cpu_ready_o, cpu_clock_o, cpu_addr_oe_o;
    logic [15:0] cpu_addr_i, cpu_addr_o;
    logic [7:0]  cpu_data_i, cpu_data_o;
    logic        cpu_data_oe_o, cpu_we_i, cpu_we_o, cpu_we_oe_o;
    logic        ram_addr_a10_o, ram_addr_a11_o, ram_addr_a15_o, ram_addr_a16_o;
    logic        ram_oe_o, ram_we_o;
    logic        io_oe_o, pia1_cs_o, pia2_cs_o, via_cs_o;

    logic [7:0]  cpu_wdata;         // Byte the modelled CPU writes
    logic [7:0]  mem [0:131071];    // 128 KiB SRAM
    logic [16:0] sram_addr;
    int          seed = 66;

    // Memory map, straight from the PET layout
    function automatic logic in_ram(input logic [15:0] a);
        return a < 16'h9000;
    endfunction
    function automatic logic in_io(input logic [15:0] a);
        return a[15:8] == 8'hE8;
    endfunction
    function automatic logic is_rom(input logic [15:0] a);
        return !in_ram(a) && !in_io(a);
    endfunction

    `include "tb_pet_checks.svh"

    pet_system #(.WB_CLOCK_MHZ(64)) pet_system_inst (.*);

    initial begin
        wb_clock_i = 1'b0;
        forever #(CLK_NS / 2) wb_clock_i = ~wb_clock_i;
    end

    // SRAM sees the muxed upper lines, lower lines from whoever owns the bus
    assign sram_addr = {ram_addr_a16_o, ram_addr_a15_o,
                        cpu_be_o ? cpu_addr_i[14:12] : cpu_addr_o[14:12],
                        ram_addr_a11_o, ram_addr_a10_o,
                        cpu_be_o ? cpu_addr_i[9:0] : cpu_addr_o[9:0]};
    assign cpu_data_i = ram_oe_o ? mem[sram_addr] : 8'hFF;   // Pull-ups when idle

    always @(posedge wb_clock_i) begin
        if (ram_we_o) begin
            mem[sram_addr] <= cpu_data_oe_o ? cpu_data_o : cpu_wdata;
        end
    end

    // Returns at the edge where the phase counter holds p
    task automatic wait_phase(input int p);
        @(posedge cpu_be_o);                        // Edge at phase 3
        repeat ((p + 61) % 64) @(posedge wb_clock_i);
    endtask

    // One host transfer, called at a rising edge
    task automatic host_transfer(input logic we, input logic [16:0] addr, input logic [7:0] wd,
                                 output logic [7:0] rd, output int stalled);
        int n;
        #5;
        wb_cycle_i  = 1'b1;
        wb_strobe_i = 1'b1;
        wb_we_i     = we;
        wb_addr_i   = {3'b000, addr};
        wb_data_i   = wd;
        stalled = 0;
        @(negedge wb_clock_i);
        while (wb_stall_o) begin
            stalled++;
            @(negedge wb_clock_i);
        end
        @(posedge wb_clock_i);                      // Accepted here
        #5 wb_strobe_i = 1'b0;
        n = 0;
        do begin
            @(negedge wb_clock_i);
            n++;
            if (n == 1) begin                       // Host owns the SRAM lines now
                expect_eq("ram_addr a16/a15/a11/a10", {addr[16], addr[15], addr[11], addr[10]},
                    {ram_addr_a16_o, ram_addr_a15_o, ram_addr_a11_o, ram_addr_a10_o});
                expect_eq("cpu_addr_o", addr[15:0], cpu_addr_o);
            end
            expect_eq("cpu_data_oe_o", we, cpu_data_oe_o);  // Data driven on writes only
        end while (!wb_ack_o && n < 8);
        expect_eq("wb_ack_o delay", 3, n);
        rd = wb_data_o;
        @(posedge wb_clock_i);
        #5 wb_cycle_i = 1'b0;
    endtask

    // One CPU cycle on addr, checking every strobe against the phase
    task automatic cpu_cycle(input logic [15:0] addr, input logic we);
        logic io_w, bv_w, phi_w;
        wait_phase(30);
        #5;
        cpu_addr_i = addr;
        cpu_we_i   = we;
        wait_phase(3);
        for (int k = 3; k <= 18; k++) begin
            @(negedge wb_clock_i);
            io_w  = (k >= 8) && (k <= 16);
            bv_w  = (k >= 6) && (k <= 16);
            phi_w = (k >= 10) && (k <= 14);
            expect_eq("pia1_cs_o", addr[15:4] == 12'hE81 && io_w, pia1_cs_o);
            expect_eq("pia2_cs_o", addr[15:4] == 12'hE82 && io_w, pia2_cs_o);
            expect_eq("via_cs_o", addr[15:4] == 12'hE84 && io_w, via_cs_o);
            expect_eq("io_oe_o", in_io(addr) && bv_w, io_oe_o);
            expect_eq("ram_oe_o", in_ram(addr) && io_w && !we, ram_oe_o);
            expect_eq("ram_we_o", in_ram(addr) && phi_w && we, ram_we_o);
            expect_eq("cpu_data_oe_o", 0, cpu_data_oe_o);   // Host off the data bus
            @(posedge wb_clock_i);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        logic [16:0] a;
        logic [7:0]  d, r;
        int          st, k, hi;
        time         t0;
        rst_n_i = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        wb_we_i = 1'b0;
        wb_cycle_i = 1'b0;
        wb_strobe_i = 1'b0;
        cpu_addr_i = 16'hF000;
        cpu_we_i = 1'b0;
        cpu_wdata = 8'h5A;
        for (int i = 0; i < 131072; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ {7'd0, i[16]};
        end

        // 1: reset state, during reset and up to the first BE rise
        for (int c = 0; c < 8; c++) begin
            @(negedge wb_clock_i);
            expect_eq("cpu_be_o", 0, cpu_be_o);
            expect_eq("cpu_clock_o", 0, cpu_clock_o);
            expect_eq("ram_oe_o", 0, ram_oe_o);
            expect_eq("ram_we_o", 0, ram_we_o);
            expect_eq("chip selects", 0, {pia1_cs_o, pia2_cs_o, via_cs_o});
            expect_eq("wb_stall_o", 1, wb_stall_o);
            if (c == 3) begin
                @(posedge wb_clock_i);
                #5 rst_n_i = 1'b1;
            end
        end
        finish_test("reset state");

        // 2: phase schedule
        wait_phase(3);
        t0 = $time;
        hi = 0;
        k  = 3;
        while (cpu_be_o && k < 40) begin
            @(negedge wb_clock_i);
            if (cpu_clock_o) begin
                if (hi == 0) expect_eq("cpu_clock_o rise phase", 10, k);
                hi++;
            end
            if (cpu_be_o) k++;
            @(posedge wb_clock_i);
        end
        expect_eq("cpu_be_o fall phase", 17, k);
        expect_eq("cpu_clock_o high clocks", 5, hi);
        @(posedge cpu_be_o);
        expect_eq("cpu_be_o period ns", 64 * CLK_NS, $time - t0);
        finish_test("phase schedule");

        // 3: host write then read back
        for (int i = 0; i < 20; i++) begin
            a = $random(seed);
            d = $random(seed);
            @(posedge wb_clock_i);
            host_transfer(1'b1, a, d, r, st);
            @(posedge wb_clock_i);
            host_transfer(1'b0, a, 8'h00, r, st);
            expect_eq("wb_data_o", d, r);
        end
        finish_test("host round trip");

        // 4: request parked from phase 0 waits for the host window
        wait_phase(0);
        host_transfer(1'b0, 17'h1_2345, 8'h00, r, st);
        expect_eq("wb_stall_o high clocks", 20, st);
        finish_test("arbitration");

        // 5: CPU-side decode across the map
        cpu_wdata = 8'hC3;
        cpu_cycle(16'h1234, 1'b0);
        cpu_cycle(16'h8400, 1'b0);
        cpu_cycle(16'h2222, 1'b1);
        cpu_cycle(16'hE812, 1'b0);
        cpu_cycle(16'hE823, 1'b0);
        cpu_cycle(16'hE845, 1'b1);
        cpu_cycle(16'hE880, 1'b0);
        cpu_cycle(16'hF000, 1'b0);
        cpu_cycle(16'hC123, 1'b1);
        expect_eq("mem[2222]", 8'hC3, mem[17'h02222]);
        finish_test("cpu decode");

        // 6: address muxing for both owners
        for (int i = 0; i < 6; i++) begin
            wait_phase(30);
            #5 cpu_addr_i = $random(seed);
            cpu_we_i = 1'b0;
            @(posedge wb_clock_i);
            a = $random(seed);
            host_transfer(1'b0, a, 8'h00, r, st);
        end
        finish_test("address mux");

        $display("Tests %0d, failed %0d, checks passed %0d, checks failed %0d",
                 tests_run, tests_failed, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== pet_bus.f ====
+incdir+tests
verilog/pet_pkg.sv
verilog/wb_bus_if.sv
verilog/bus_sequencer.sv
verilog/ram_controller.sv
verilog/address_decoder.sv
verilog/pet_system.sv
tests/tb_pet_system.sv

// ==== Bender.yml ====
package:
  name: pet_bus

sources:
  - verilog/pet_pkg.sv
  - verilog/wb_bus_if.sv
  - verilog/bus_sequencer.sv
  - verilog/ram_controller.sv
  - verilog/address_decoder.sv
  - verilog/pet_system.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_pet_system.sv
